// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_aud_player
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= sim.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test completed successfully" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/aud_dac_serializer.sv ====
`default_nettype none

module aud_dac_serializer (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_daclrck,
    input  wire                         i_bclk,
    input  wire                         i_busy,
    input  wire [aud_pkg::SAMPLE_W-1:0] i_word,
    input  wire                         i_word_valid,
    output logic                        o_dacdat
);

    import aud_pkg::*;

    logic [2:0]          lrck_sync;
    logic [2:0]          bclk_sync;
    logic                frame_start;  // lrck fell, left half begins
    logic                bclk_fall;
    logic                left_half;
    logic [SAMPLE_W-1:0] word_r;
    logic [SAMPLE_W-1:0] shift_r;

    assign frame_start = lrck_sync[2] & ~lrck_sync[1];
    assign bclk_fall   = bclk_sync[2] & ~bclk_sync[1];
    assign left_half   = ~lrck_sync[1];

    assign o_dacdat = shift_r[SAMPLE_W-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrck_sync <= '0;
            bclk_sync <= '0;
            word_r    <= '0;
            shift_r   <= '0;
        end else begin
            lrck_sync <= {lrck_sync[1:0], i_daclrck};
            bclk_sync <= {bclk_sync[1:0], i_bclk};

            if (i_word_valid)
                word_r <= i_word;
            else if (frame_start && !i_busy)
                word_r <= '0;  // paused or idle, silence next frame

            // msb sits on the line for the whole first bit period
            if (frame_start)
                shift_r <= word_r;
            else if (bclk_fall && left_half)
                shift_r <= {shift_r[SAMPLE_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// ==== hw/aud_interp.sv ====
`default_nettype none

module aud_interp (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_tick,
    input  wire                         i_advance,
    input  wire                         i_slow,
    input  wire                         i_load,
    input  wire                         i_interp,
    input  wire [aud_pkg::SPEED_W-1:0]  i_phase,
    input  wire [aud_pkg::SPEED_W-1:0]  i_speed,
    input  wire [aud_pkg::SAMPLE_W-1:0] i_sram_data,
    output logic [aud_pkg::SAMPLE_W-1:0] o_word,
    output logic                        o_word_valid
);

    import aud_pkg::*;

    localparam int DK_W  = SAMPLE_W + SPEED_W + 2;  // diff times phase
    localparam int SCL_W = DK_W + 18;                // times reciprocal

    logic [SAMPLE_W-1:0]      a_r;          // sample being played
    logic [16:0]              recip;
    logic signed [SAMPLE_W:0] diff;         // B - A
    logic signed [DK_W-1:0]   diff_k;
    logic signed [SCL_W-1:0]  scaled;
    logic [SAMPLE_W-1:0]      interp_word;
    logic [SAMPLE_W-1:0]      word_n;

    assign recip = RECIP_Q16[i_speed];

    // B is the word at the current sram address
    assign diff   = $signed({i_sram_data[SAMPLE_W-1], i_sram_data})
                  - $signed({a_r[SAMPLE_W-1], a_r});
    assign diff_k = diff * $signed({1'b0, i_phase});
    assign scaled = diff_k * $signed({1'b0, recip});

    // result lies between A and B so 16-bit wrap is harmless
    assign interp_word = a_r + scaled[SAMPLE_W+15:16];

    assign word_n = (i_slow && i_interp) ? interp_word : a_r;

    always_ff @(posedge i_clk) begin
        if (i_load)
            a_r <= i_sram_data;  // first sample after start
        else if (i_tick && i_advance)
            a_r <= i_sram_data;
    end

    always_ff @(posedge i_clk) begin
        if (i_tick)
            o_word <= word_n;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_word_valid <= 1'b0;
        else
            o_word_valid <= i_tick;
    end

endmodule

`default_nettype wire

// ==== hw/aud_pkg.sv ====
`default_nettype none

package aud_pkg;

    localparam int ADDR_W   = 20;  // sram word address
    localparam int SAMPLE_W = 16;  // signed pcm sample
    localparam int SPEED_W  = 4;   // 0 behaves as 1

    // sequencer states
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_PLAY    = 2'd1;
    localparam logic [1:0] ST_PAUSE   = 2'd2;
    localparam logic [1:0] ST_REVERSE = 2'd3;

    // floor(65536 / n), entry 0 same as entry 1
    localparam logic [16:0] RECIP_Q16 [0:15] = '{
        17'd65536,
        17'd65536,
        17'd32768,
        17'd21845,
        17'd16384,
        17'd13107,
        17'd10922,
        17'd9362,
        17'd8192,
        17'd7281,
        17'd6553,
        17'd5957,
        17'd5461,
        17'd5041,
        17'd4681,
        17'd4369
    };

endpackage

`default_nettype wire

// ==== hw/aud_player.sv ====
`default_nettype none

module aud_player (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_start,
    input  wire                         i_pause,
    input  wire                         i_stop,
    input  wire                         i_reverse,
    input  wire                         i_fast,
    input  wire [aud_pkg::SPEED_W-1:0]  i_speed,
    input  wire                         i_interp,
    input  wire [aud_pkg::ADDR_W-1:0]   i_end_addr,
    input  wire                         i_daclrck,
    input  wire                         i_bclk,
    input  wire [aud_pkg::SAMPLE_W-1:0] i_sram_data,
    output logic [aud_pkg::ADDR_W-1:0]  o_sram_addr,
    output logic                        o_dacdat,
    output logic                        o_busy
);

    import aud_pkg::*;

    logic               seq_tick;
    logic               seq_advance;
    logic               seq_slow;
    logic               seq_load;
    logic [SPEED_W-1:0] seq_phase;
    logic [SAMPLE_W-1:0] word;
    logic               word_valid;

    aud_sequencer u_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .i_reverse   (i_reverse),
        .i_fast      (i_fast),
        .i_speed     (i_speed),
        .i_end_addr  (i_end_addr),
        .i_daclrck   (i_daclrck),
        .o_sram_addr (o_sram_addr),
        .o_tick      (seq_tick),
        .o_advance   (seq_advance),
        .o_slow      (seq_slow),
        .o_busy      (o_busy),
        .o_phase     (seq_phase),
        .o_load      (seq_load)
    );

    aud_interp u_interp (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_tick       (seq_tick),
        .i_advance    (seq_advance),
        .i_slow       (seq_slow),
        .i_load       (seq_load),
        .i_interp     (i_interp),
        .i_phase      (seq_phase),
        .i_speed      (i_speed),
        .i_sram_data  (i_sram_data),
        .o_word       (word),
        .o_word_valid (word_valid)
    );

    aud_dac_serializer u_ser (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_daclrck    (i_daclrck),
        .i_bclk       (i_bclk),
        .i_busy       (o_busy),
        .i_word       (word),
        .i_word_valid (word_valid),
        .o_dacdat     (o_dacdat)
    );

endmodule

`default_nettype wire

// ==== hw/aud_sequencer.sv ====
`default_nettype none

module aud_sequencer (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire                        i_start,
    input  wire                        i_pause,
    input  wire                        i_stop,
    input  wire                        i_reverse,
    input  wire                        i_fast,
    input  wire [aud_pkg::SPEED_W-1:0] i_speed,
    input  wire [aud_pkg::ADDR_W-1:0]  i_end_addr,
    input  wire                        i_daclrck,
    output logic [aud_pkg::ADDR_W-1:0] o_sram_addr,
    output logic                       o_tick,
    output logic                       o_advance,
    output logic                       o_slow,
    output logic                       o_busy,
    output logic [aud_pkg::SPEED_W-1:0] o_phase,
    output logic                       o_load
);

    import aud_pkg::*;

    logic [2:0]         lrck_sync;
    logic               lrck_fall;
    logic               tick_r;
    logic               load_r;
    logic [1:0]         state_r, state_n;
    logic [ADDR_W-1:0]  addr_r, addr_n;
    logic [SPEED_W-1:0] phase_r, phase_n;
    logic [SPEED_W-1:0] speed_n;
    logic [ADDR_W-1:0]  step;
    logic [ADDR_W:0]    fwd_sum;
    logic               fwd_over;
    logic               rev_under;
    logic               last_phase;
    logic               play_st;

    // lrck falling edge, two sync flops plus one for the edge
    assign lrck_fall = lrck_sync[2] & ~lrck_sync[1];

    assign speed_n    = (i_speed == '0) ? SPEED_W'(1) : i_speed;
    assign play_st    = (state_r == ST_PLAY) || (state_r == ST_REVERSE);
    assign o_slow     = (state_r == ST_PLAY) && !i_fast;
    assign last_phase = phase_r >= (speed_n - 1'b1);
    assign step       = o_slow ? ADDR_W'(1) : ADDR_W'(speed_n);

    assign fwd_sum   = {1'b0, addr_r} + {1'b0, step};
    assign fwd_over  = fwd_sum > {1'b0, i_end_addr};
    assign rev_under = addr_r < ADDR_W'(speed_n);

    // no tick in the load cycle, A is being captured then
    assign o_tick      = tick_r & play_st & ~load_r;
    assign o_advance   = o_tick & (~o_slow | last_phase);
    assign o_phase     = phase_r;
    assign o_busy      = play_st;
    assign o_load      = load_r;
    assign o_sram_addr = addr_r;

    always_comb begin
        state_n = state_r;
        addr_n  = addr_r;
        phase_n = phase_r;

        case (state_r)
            ST_IDLE: begin
                addr_n  = '0;
                phase_n = '0;
                if (i_start) begin
                    state_n = i_reverse ? ST_REVERSE : ST_PLAY;
                    addr_n  = i_reverse ? i_end_addr : '0;
                end
            end
            ST_PAUSE: begin
                if (i_stop) begin
                    state_n = ST_IDLE;
                    addr_n  = '0;
                end else if (!i_pause) begin
                    state_n = i_reverse ? ST_REVERSE : ST_PLAY;
                end
            end
            default: begin  // play or reverse
                if (i_stop) begin
                    state_n = ST_IDLE;
                    addr_n  = '0;
                end else if (i_pause) begin
                    state_n = ST_PAUSE;
                end else begin
                    state_n = i_reverse ? ST_REVERSE : ST_PLAY;
                    if (load_r) begin
                        // point at the sample after A
                        if (state_r == ST_PLAY)
                            addr_n = fwd_sum[ADDR_W-1:0];
                        else if (!rev_under)
                            addr_n = addr_r - ADDR_W'(speed_n);
                    end else if (o_tick) begin
                        if (o_slow && !last_phase) begin
                            phase_n = phase_r + 1'b1;
                        end else if (state_r == ST_PLAY) begin
                            phase_n = '0;
                            if (fwd_over) begin
                                state_n = ST_IDLE;
                                addr_n  = '0;
                            end else begin
                                addr_n = fwd_sum[ADDR_W-1:0];
                            end
                        end else begin
                            phase_n = '0;
                            if (rev_under) begin  // would go below 0
                                state_n = ST_IDLE;
                                addr_n  = '0;
                            end else begin
                                addr_n = addr_r - ADDR_W'(speed_n);
                            end
                        end
                    end
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrck_sync <= '0;
            tick_r    <= 1'b0;
            load_r    <= 1'b0;
            state_r   <= ST_IDLE;
            addr_r    <= '0;
            phase_r   <= '0;
        end else begin
            lrck_sync <= {lrck_sync[1:0], i_daclrck};
            tick_r    <= lrck_fall;
            load_r    <= (state_r == ST_IDLE) && i_start;
            state_r   <= state_n;
            addr_r    <= addr_n;
            phase_r   <= phase_n;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/aud_pkg.sv
hw/aud_sequencer.sv
hw/aud_interp.sv
hw/aud_dac_serializer.sv
hw/aud_player.sv
test/tb_aud_player.sv

// ==== test/tb_aud_player.sv ====
`default_nettype none

module tb_aud_player;

    timeunit 1ns;
    timeprecision 100ps;

    import aud_pkg::*;

    localparam int FRAME_CYC   = 512;                              // 64 bclk of 8 cycles
    localparam int TEST_FRAMES = 16 + 14 + 24 + 24 + 14 + 19 + 9;  // frames per test
    localparam int TIMEOUT_CYC = TEST_FRAMES * FRAME_CYC * 3 / 2;

    logic                i_clk       = 1'b0;
    logic                i_rst_n     = 1'b0;
    logic                i_start     = 1'b0;
    logic                i_pause     = 1'b0;
    logic                i_stop      = 1'b0;
    logic                i_reverse   = 1'b0;
    logic                i_fast      = 1'b0;
    logic [SPEED_W-1:0]  i_speed     = 4'd1;
    logic                i_interp    = 1'b0;
    logic [ADDR_W-1:0]   i_end_addr  = '0;
    logic                i_daclrck   = 1'b0;
    logic                i_bclk      = 1'b0;
    logic [SAMPLE_W-1:0] i_sram_data = '0;
    logic [ADDR_W-1:0]   o_sram_addr;
    logic                o_dacdat;
    logic                o_busy;

    logic [15:0] mem [0:63];
    logic [15:0] frames[$];     // decoded left words
    logic [15:0] exp_words[$];  // reference model output
    logic [15:0] rx_word   = '0;
    logic [8:0]  codec_cnt = '0;
    int          bit_idx   = 0;
    int          cycle_cnt = 0;

    aud_player DUT (.*);

    always #50 i_clk = ~i_clk;

    // bclk is cnt[2] and lrck is cnt[8] so lrck moves on a bclk fall
    always @(negedge i_clk) begin
        codec_cnt = codec_cnt + 9'd1;
        i_bclk    <= codec_cnt[2];
        i_daclrck <= codec_cnt[8];
    end

    always @(negedge i_clk)
        i_sram_data <= (o_sram_addr < 64) ? mem[o_sram_addr[5:0]] : 16'h0;

    // left word msb first and every bit after bit 15 zero
    always @(posedge i_bclk) begin
        if (!i_daclrck) begin
            if (bit_idx < 16) begin
                rx_word = {rx_word[14:0], o_dacdat};
                if (bit_idx == 15)
                    frames.push_back(rx_word);
            end else begin
                check_value("o_dacdat pad bit", o_dacdat, 0);
            end
            bit_idx++;
        end else begin
            check_value("o_dacdat right bit", o_dacdat, 0);
            bit_idx = 0;
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYC) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, want);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic wait_mid_frame();
        @(posedge i_daclrck);
        @(negedge i_clk);
    endtask

    task automatic start_play(input bit fast, input int spd, input bit interp,
                              input bit rev, input int end_a);
        wait_mid_frame();
        i_fast     = fast;
        i_speed    = 4'(spd);
        i_interp   = interp;
        i_reverse  = rev;
        i_end_addr = 20'(end_a);
        frames.delete();  // next frame is the one of the first tick
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        check_value("o_busy", o_busy, 1);
    endtask

    // address points at B and A is the sample one step behind
    task automatic model_forward(input bit fast, input bit interp, input int spd,
                                 input int end_a);
        int          step;
        int          addr;
        int          k;
        bit          done;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] w;
        longint      d;
        longint      p;
        step = fast ? spd : 1;
        a    = mem[0];
        addr = step;
        k    = 0;
        done = 1'b0;
        exp_words.delete();
        while (!done) begin
            b = mem[addr];
            d = $signed(b) - $signed(a);
            p = (d * k * longint'(RECIP_Q16[spd])) >>> 16;
            w = a + p[15:0];
            exp_words.push_back((!fast && interp) ? w : a);
            if (!fast && k < spd - 1) begin
                k++;
            end else begin
                k    = 0;
                done = (addr + step > end_a);
                a    = b;
                addr += step;
            end
        end
    endtask

    task automatic model_reverse(input int spd, input int end_a);
        int          addr;
        bit          done;
        logic [15:0] a;
        exp_words.delete();
        a    = mem[end_a];
        addr = (end_a >= spd) ? end_a - spd : end_a;
        done = 1'b0;
        while (!done) begin
            exp_words.push_back(a);
            done = (addr < spd);
            a    = mem[addr];
            addr -= spd;
        end
    endtask

    // one silent frame leads and hold_len zeros go in before word hold_at
    task automatic compare_frames(input int hold_at, input int hold_len);
        logic [15:0] want[$];
        want.push_back(16'h0);
        foreach (exp_words[i]) begin
            if (i == hold_at)
                repeat (hold_len) want.push_back(16'h0);
            want.push_back(exp_words[i]);
        end
        want.push_back(16'h0);
        want.push_back(16'h0);
        while (frames.size() < want.size())
            @(negedge i_clk);
        foreach (want[i])
            check_value("o_dacdat frame", frames[i], want[i]);
        check_value("o_busy", o_busy, 0);
        check_value("o_sram_addr", o_sram_addr, 0);
    endtask

    task automatic normal_play();
        start_play(0, 1, 0, 0, 12);
        model_forward(0, 0, 1, 12);
        compare_frames(-1, 0);
    endtask

    task automatic fast_forward();
        start_play(1, 3, 0, 0, 30);
        model_forward(1, 0, 3, 30);
        compare_frames(-1, 0);
    endtask

    task automatic slow_play(input bit interp);
        start_play(0, 4, interp, 0, 5);
        model_forward(0, interp, 4, 5);
        compare_frames(-1, 0);
    endtask

    task automatic reverse_play();
        start_play(0, 2, 0, 1, 20);
        model_reverse(2, 20);
        compare_frames(-1, 0);
        i_reverse = 1'b0;
    endtask

    task automatic pause_resume();
        logic [ADDR_W-1:0] held;
        start_play(0, 1, 0, 0, 12);
        model_forward(0, 0, 1, 12);
        held = ADDR_W'(4 + 1);  // four words out and B one past A
        repeat (4) wait_mid_frame();
        i_pause = 1'b1;
        @(negedge i_clk);
        check_value("o_busy", o_busy, 0);
        check_value("o_sram_addr", o_sram_addr, held);
        repeat (3) wait_mid_frame();
        check_value("o_sram_addr", o_sram_addr, held);
        i_pause = 1'b0;
        compare_frames(4, 3);
    endtask

    task automatic stop_midway();
        start_play(0, 1, 0, 0, 40);
        model_forward(0, 0, 1, 40);
        repeat (5) wait_mid_frame();
        i_stop = 1'b1;
        @(negedge i_clk);
        i_stop = 1'b0;
        check_value("o_busy", o_busy, 0);
        check_value("o_sram_addr", o_sram_addr, 0);
        while (exp_words.size() > 5)
            void'(exp_words.pop_back());
        compare_frames(-1, 0);
    endtask

    initial begin
        logic [31:0] lfsr;
        lfsr = 32'h75e3186b;
        for (int i = 0; i < 64; i++) begin
            for (int j = 0; j < 16; j++) begin
                lfsr      = lfsr_next(lfsr);
                mem[i][j] = lfsr[0];
            end
        end
        repeat (10) @(negedge i_clk);
        i_rst_n = 1'b1;
        normal_play();
        fast_forward();
        slow_play(0);
        slow_play(1);
        reverse_play();
        pause_resume();
        stop_midway();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
